// ==== src/gru_pkg.sv ====
package gru_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes and fixed-point format
	////////////////////////////////////////////////////////////////////////////
	localparam int NB_INPUTS  = 4;
	localparam int NB_NEURONS = 4;
	localparam int DATA_W     = 16;
	localparam int FRAC_W     = 8;
	localparam int ACC_W      = 32;
	localparam int FIX_ONE    = 256;
	localparam int LOOP_LEN   = (NB_INPUTS > NB_NEURONS) ? NB_INPUTS : NB_NEURONS;
	localparam int NB_GATES   = 3;
	localparam int DATA_MAX   = 2**(DATA_W-1) - 1;
	localparam int DATA_MIN   = -(2**(DATA_W-1));

	// bias slot, two reads per element, then the finish slot
	localparam int DOT_SLOTS  = 2*LOOP_LEN + 2;
	localparam int SLOT_W     = $clog2(DOT_SLOTS);
	localparam int ROW_W      = NB_GATES * NB_NEURONS;

	////////////////////////////////////////////////////////////////////////////
	// address map
	////////////////////////////////////////////////////////////////////////////
	localparam int ADR_W  = 8;
	localparam int MEM_AW = 7;
	localparam logic [ADR_W-1:0] IN_W_BASE  = 8'h00;
	localparam logic [ADR_W-1:0] REC_W_BASE = 8'h30;
	localparam logic [ADR_W-1:0] BIAS_BASE  = 8'h60;
	localparam logic [ADR_W-1:0] X_BASE     = 8'h70;
	localparam logic [ADR_W-1:0] HPREV_BASE = 8'h78;
	localparam logic [ADR_W-1:0] HOUT_BASE  = 8'h80;
	localparam logic [ADR_W-1:0] CTRL_ADR   = 8'h90;
	localparam logic [ADR_W-1:0] STAT_ADR   = 8'h91;
	localparam int MEM_DEPTH = 108;

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [ACC_W-1:0]  acc_t;
	typedef data_t [NB_INPUTS-1:0]    vec_in_t;
	typedef data_t [NB_NEURONS-1:0]   vec_state_t;
	typedef logic [MEM_AW-1:0]        mem_addr_t;

	typedef enum logic [1:0] {gate_z, gate_r, gate_h} gate_t;

	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [ADR_W-1:0] adr;
		data_t            dat;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		data_t dat;
	} wb_rsp_t;

	// the arithmetic shift of the Q8.8 product truncates toward minus infinity
	function automatic acc_t qmul(input data_t a, input data_t b);
		acc_t p;
		p = acc_t'(a) * acc_t'(b);
		return p >>> FRAC_W;
	endfunction

	function automatic data_t sat16(input acc_t v);
		if (v > DATA_MAX)
			return data_t'(DATA_MAX);
		else if (v < DATA_MIN)
			return data_t'(DATA_MIN);
		return data_t'(v);
	endfunction

endpackage

// ==== src/gru_weight_mem.sv ====
`timescale 1ns/10ps

module gru_weight_mem import gru_pkg::*; (
	input  logic      clk,
	input  logic      we,
	input  mem_addr_t waddr,
	input  data_t     wdata,
	input  mem_addr_t bus_addr,
	input  mem_addr_t rd_addr,
	output data_t     bus_rdata,
	output data_t     rd_data
);

	// input weights, recurrent weights, then biases
	data_t mem [MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// addresses past the biases read back as zero
	always_ff @(posedge clk) begin
		if (bus_addr < MEM_DEPTH)
			bus_rdata <= mem[bus_addr];
		else
			bus_rdata <= '0;
	end

	// datapath read with one cycle of latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== src/gru_mac.sv ====
`timescale 1ns/10ps

module gru_mac import gru_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  preload,
	input  logic  step,
	input  data_t bias,
	input  data_t a,
	input  data_t b,
	output data_t sum_sat
);

	acc_t acc;

	// the full 32-bit sum saturates only where it leaves the lane
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			acc <= '0;
		else if (preload)
			acc <= acc_t'(bias);
		else if (step)
			acc <= acc + qmul(a, b);
	end

	assign sum_sat = sat16(acc);

endmodule

// ==== src/gru_activation.sv ====
`timescale 1ns/10ps

module gru_activation import gru_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  gate_t gate,
	input  data_t x,
	input  logic  en,
	output data_t y
);

	acc_t  sig_v;
	data_t y_d;

	always_comb begin
		// hard sigmoid x/4 + 0.5
		sig_v = (acc_t'(x) >>> 2) + acc_t'(FIX_ONE/2);
		if (gate == gate_h) begin
			if (x > data_t'(FIX_ONE))
				y_d = data_t'(FIX_ONE);
			else if (x < data_t'(-FIX_ONE))
				y_d = data_t'(-FIX_ONE);
			else
				y_d = x;
		end else begin
			if (sig_v > FIX_ONE)
				y_d = data_t'(FIX_ONE);
			else if (sig_v < 0)
				y_d = '0;
			else
				y_d = data_t'(sig_v);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			y <= '0;
		else if (en)
			y <= y_d;
	end

endmodule

// ==== src/gru_datapath.sv ====
`timescale 1ns/10ps

module gru_datapath import gru_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  data_t      rd_data,
	input  logic       preload,
	input  logic       step,
	input  logic       finish,
	input  gate_t      gate,
	input  logic [1:0] elem,
	input  logic [1:0] neuron,
	input  vec_in_t    x_vec,
	input  vec_state_t h_prev,
	output vec_state_t h_new,
	output logic       h_valid
);

	data_t      w_hold;
	data_t      rec_a;
	data_t      rec_b;
	data_t      in_sum;
	data_t      rec_sum;
	data_t      act_x;
	data_t      act_y;
	data_t      z_j;
	acc_t       blend;
	vec_state_t z_q;
	vec_state_t r_q;
	logic       res_vld;
	gate_t      res_gate;
	logic [1:0] res_neuron;

	// candidate gate scales the recurrent product by r of that element
	always_comb begin
		if (gate == gate_h) begin
			rec_a = sat16(qmul(rd_data, h_prev[elem]));
			rec_b = r_q[elem];
		end else begin
			rec_a = rd_data;
			rec_b = h_prev[elem];
		end
	end

	// input weight arrives one half-step before the recurrent one
	gru_mac in_lane_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.preload (preload),
		.step    (step),
		.bias    (rd_data),
		.a       (w_hold),
		.b       (x_vec[elem]),
		.sum_sat (in_sum)
	);

	gru_mac rec_lane_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.preload (preload),
		.step    (step),
		.bias    ('0),
		.a       (rec_a),
		.b       (rec_b),
		.sum_sat (rec_sum)
	);

	assign act_x = sat16(acc_t'(in_sum) + acc_t'(rec_sum));

	gru_activation act_i (
		.clk   (clk),
		.rst_n (rst_n),
		.gate  (gate),
		.x     (act_x),
		.en    (finish),
		.y     (act_y)
	);

	assign z_j   = z_q[res_neuron];
	assign blend = qmul(z_j, h_prev[res_neuron]) + qmul(data_t'(FIX_ONE) - z_j, act_y);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_vld <= 1'b0;
			h_valid <= 1'b0;
		end else begin
			res_vld <= finish;
			h_valid <= res_vld && res_gate == gate_h && res_neuron == 2'(NB_NEURONS-1);
		end
	end

	always_ff @(posedge clk) begin
		w_hold <= rd_data;
		if (finish) begin
			res_gate   <= gate;
			res_neuron <= neuron;
		end
		if (res_vld) begin
			case (res_gate)
				gate_z:  z_q[res_neuron]   <= act_y;
				gate_r:  r_q[res_neuron]   <= act_y;
				default: h_new[res_neuron] <= sat16(blend);
			endcase
		end
	end

endmodule

// ==== src/gru_sequencer.sv ====
`timescale 1ns/10ps

module gru_sequencer import gru_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	output logic       busy,
	output logic       done,
	output mem_addr_t  rd_addr,
	output logic       preload,
	output logic       step,
	output logic       finish,
	output gate_t      gate,
	output logic [1:0] elem,
	output logic [1:0] neuron
);

	typedef enum logic [1:0] {st_idle, st_run, st_drain} state_t;

	state_t            state;
	logic [SLOT_W-1:0] slot;
	logic [SLOT_W-1:0] slot_m1;
	gate_t             cur_gate;
	logic [1:0]        cur_neuron;
	logic [1:0]        k;
	logic              pre_c;
	logic              step_c;
	logic              fin_c;
	logic [1:0]        drain_sr;
	int                addr_base;
	int                addr_off;

	////////////////////////////////////////////////////////////////////////////
	// slot decode for the bias, then input and recurrent weight per element
	////////////////////////////////////////////////////////////////////////////
	assign slot_m1 = slot - 1'b1;
	assign k       = slot_m1[2:1];

	assign pre_c  = state == st_run && slot == '0;
	assign step_c = state == st_run && slot != '0 && !slot[0];
	assign fin_c  = state == st_run && slot == SLOT_W'(DOT_SLOTS-1);

	always_comb begin
		addr_off = int'(cur_gate) * NB_NEURONS + int'(cur_neuron);
		if (slot == '0)
			addr_base = int'(BIAS_BASE);
		else if (slot[0])
			addr_base = int'(IN_W_BASE) + int'(k) * ROW_W;
		else
			addr_base = int'(REC_W_BASE) + int'(k) * ROW_W;
		rd_addr = mem_addr_t'(addr_base + addr_off);
	end

	assign busy = state != st_idle;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			slot       <= '0;
			cur_gate   <= gate_z;
			cur_neuron <= '0;
			done       <= 1'b0;
			drain_sr   <= '0;
			preload    <= 1'b0;
			step       <= 1'b0;
			finish     <= 1'b0;
			gate       <= gate_z;
			elem       <= '0;
			neuron     <= '0;
		end else begin
			// controls trail the address by the memory latency
			preload  <= pre_c;
			step     <= step_c;
			finish   <= fin_c;
			gate     <= cur_gate;
			elem     <= k;
			neuron   <= cur_neuron;
			// activation, blend and output load follow the last finish
			drain_sr <= {drain_sr[0], state == st_drain && finish};

			case (state)
				st_idle: begin
					if (start) begin
						state      <= st_run;
						slot       <= '0;
						cur_gate   <= gate_z;
						cur_neuron <= '0;
						done       <= 1'b0;
					end
				end
				st_run: begin
					if (fin_c) begin
						slot <= '0;
						if (cur_gate == gate_z)
							cur_gate <= gate_r;
						else if (cur_neuron == 2'(NB_NEURONS-1)) begin
							cur_neuron <= '0;
							if (cur_gate == gate_r)
								cur_gate <= gate_h;
							else
								state <= st_drain;
						end else begin
							cur_neuron <= cur_neuron + 1'b1;
							if (cur_gate == gate_r)
								cur_gate <= gate_z;
						end
					end else
						slot <= slot + 1'b1;
				end
				default: begin
					if (drain_sr[1]) begin
						state <= st_idle;
						done  <= 1'b1;
					end
				end
			endcase
		end
	end

	// each strobe meets the word that was fetched for it
	a_preload_step: assert property (@(posedge clk) disable iff (!rst_n)
		!(preload && step)
		&& (!preload || $past(rd_addr) >= mem_addr_t'(BIAS_BASE))
		&& (!step || ($past(rd_addr) >= mem_addr_t'(REC_W_BASE)
			&& $past(rd_addr) < mem_addr_t'(BIAS_BASE))));

	a_counters: assert property (@(posedge clk) disable iff (!rst_n)
		slot < SLOT_W'(DOT_SLOTS));

endmodule

// ==== src/gru_wb_regs.sv ====
`timescale 1ns/10ps

module gru_wb_regs import gru_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  wb_req_t    wb_req,
	input  logic       busy,
	input  logic       done,
	input  data_t      mem_rdata,
	input  vec_state_t h_new,
	input  logic       h_valid,
	output wb_rsp_t    wb_rsp,
	output logic       mem_we,
	output mem_addr_t  mem_waddr,
	output data_t      mem_wdata,
	output logic       start,
	output vec_in_t    x_vec,
	output vec_state_t h_prev
);

	logic       ack_q;
	logic       req;
	logic       wr;
	logic       in_mem;
	logic       in_x;
	logic       in_hprev;
	logic       in_hout;
	logic       sel_mem_q;
	logic [1:0] idx;
	data_t      rdata_d;
	data_t      rdata_q;
	vec_state_t h_out;

	// a new transfer is seen once in the cycle before its ack
	assign req = wb_req.cyc & wb_req.stb & ~ack_q;
	assign wr  = req & wb_req.we & ~busy;
	assign idx = wb_req.adr[1:0];

	assign in_mem   = wb_req.adr < MEM_DEPTH;
	assign in_x     = wb_req.adr[ADR_W-1:2] == X_BASE[ADR_W-1:2];
	assign in_hprev = wb_req.adr[ADR_W-1:2] == HPREV_BASE[ADR_W-1:2];
	assign in_hout  = wb_req.adr[ADR_W-1:2] == HOUT_BASE[ADR_W-1:2];

	assign mem_we    = wr & in_mem;
	assign mem_waddr = wb_req.adr[MEM_AW-1:0];
	assign mem_wdata = wb_req.dat;

	always_comb begin
		rdata_d = '0;
		if (in_x)
			rdata_d = x_vec[idx];
		else if (in_hprev)
			rdata_d = h_prev[idx];
		else if (in_hout)
			rdata_d = h_out[idx];
		else if (wb_req.adr == STAT_ADR)
			rdata_d = data_t'({done, busy});
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q     <= 1'b0;
			start     <= 1'b0;
			sel_mem_q <= 1'b0;
			rdata_q   <= '0;
			h_out     <= '0;
		end else begin
			ack_q <= req;
			start <= wr && wb_req.adr == CTRL_ADR && wb_req.dat[0];
			if (req) begin
				sel_mem_q <= in_mem;
				rdata_q   <= rdata_d;
			end
			if (h_valid)
				h_out <= h_new;
		end
	end

	always_ff @(posedge clk) begin
		if (wr && in_x)
			x_vec[idx] <= wb_req.dat;
		if (wr && in_hprev)
			h_prev[idx] <= wb_req.dat;
	end

	// weight words come straight from the registered memory port
	assign wb_rsp = '{ack: ack_q, dat: sel_mem_q ? mem_rdata : rdata_q};

	// the master keeps the transfer open until it sees ack
	a_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
		ack_q |-> $past(wb_req.cyc && wb_req.stb) && wb_req.cyc && wb_req.stb);

	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy);

endmodule

// ==== src/gru_cell_top.sv ====
`timescale 1ns/10ps

module gru_cell_top import gru_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	logic       mem_we;
	mem_addr_t  mem_waddr;
	data_t      mem_wdata;
	data_t      mem_rdata;
	mem_addr_t  rd_addr;
	data_t      rd_data;
	logic       start;
	logic       busy;
	logic       done;
	logic       preload;
	logic       step;
	logic       finish;
	gate_t      gate;
	logic [1:0] elem;
	logic [1:0] neuron;
	vec_in_t    x_vec;
	vec_state_t h_prev;
	vec_state_t h_new;
	logic       h_valid;

	gru_wb_regs regs_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.wb_req    (wb_req),
		.busy      (busy),
		.done      (done),
		.mem_rdata (mem_rdata),
		.h_new     (h_new),
		.h_valid   (h_valid),
		.wb_rsp    (wb_rsp),
		.mem_we    (mem_we),
		.mem_waddr (mem_waddr),
		.mem_wdata (mem_wdata),
		.start     (start),
		.x_vec     (x_vec),
		.h_prev    (h_prev)
	);

	gru_weight_mem mem_i (
		.clk       (clk),
		.we        (mem_we),
		.waddr     (mem_waddr),
		.wdata     (mem_wdata),
		.bus_addr  (wb_req.adr[MEM_AW-1:0]),
		.rd_addr   (rd_addr),
		.bus_rdata (mem_rdata),
		.rd_data   (rd_data)
	);

	gru_sequencer seq_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.busy    (busy),
		.done    (done),
		.rd_addr (rd_addr),
		.preload (preload),
		.step    (step),
		.finish  (finish),
		.gate    (gate),
		.elem    (elem),
		.neuron  (neuron)
	);

	gru_datapath dp_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_data (rd_data),
		.preload (preload),
		.step    (step),
		.finish  (finish),
		.gate    (gate),
		.elem    (elem),
		.neuron  (neuron),
		.x_vec   (x_vec),
		.h_prev  (h_prev),
		.h_new   (h_new),
		.h_valid (h_valid)
	);

endmodule

// ==== verification/gru_cell_tb.sv ====
`timescale 1ns/10ps

module gru_cell_tb import gru_pkg::*; ();

	localparam int NB_CASES   = 3;
	localparam int CASE_WORDS = NB_INPUTS + 2*NB_NEURONS;
	localparam int FILE_WORDS = MEM_DEPTH + NB_CASES*CASE_WORDS;
	localparam int ACK_LIMIT  = 16;
	localparam int POLL_LIMIT = 100;

	logic    clk;
	logic    rst_n;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	// weights, then x, h_prev and expected h per case
	data_t       case_mem [FILE_WORDS];
	logic [31:0] lfsr;
	int          errors;
	int          timeouts;
	int          checks;

	always #10 clk = ~clk;

	gru_cell_top dut_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	////////////////////////////////////////////////////////////////////////////
	// bus and check helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic transfer(input logic we, input logic [ADR_W-1:0] adr,
			input data_t wdat, output data_t rdat);
		int   n;
		logic ack_seen;
		n = 0;
		ack_seen = 1'b0;
		rdat = '0;
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		while (!ack_seen && n < ACK_LIMIT) begin
			@(posedge clk);
			ack_seen = wb_rsp.ack;
			rdat = wb_rsp.dat;
			n++;
		end
		wb_req <= '0;
		assert (ack_seen) else begin
			$display("bus transfer to address %h was never acknowledged", adr);
			timeouts++;
		end
	endtask

	task automatic check_value(input string name, input data_t exp_v, input data_t got_v);
		checks++;
		assert (got_v === exp_v) else begin
			$display("FAIL %0t %s expected %h got %h", $time, name, exp_v, got_v);
			errors++;
		end
	endtask

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic pick_addr(output int adr);
		int v;
		v = 0;
		for (int i = 0; i < 7; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
		adr = v % MEM_DEPTH;
	endtask

	task automatic wait_done();
		data_t stat;
		int    n;
		n = 0;
		stat = '0;
		while (!stat[1] && n < POLL_LIMIT) begin
			transfer(1'b0, STAT_ADR, '0, stat);
			n++;
		end
		assert (stat[1]) else begin
			$display("run did not finish within %0d status polls", POLL_LIMIT);
			timeouts++;
		end
	endtask

	task automatic run_case(input int c);
		int    base;
		data_t got;
		base = MEM_DEPTH + c*CASE_WORDS;
		for (int i = 0; i < NB_INPUTS; i++)
			transfer(1'b1, X_BASE + 8'(i), case_mem[base+i], got);
		for (int i = 0; i < NB_NEURONS; i++)
			transfer(1'b1, HPREV_BASE + 8'(i), case_mem[base+NB_INPUTS+i], got);
		transfer(1'b1, CTRL_ADR, 16'h0001, got);
		transfer(1'b0, STAT_ADR, '0, got);
		check_value($sformatf("stat case %0d", c), 16'h0001, got);
		// writes while busy must be dropped
		if (c == 1) begin
			for (int i = 0; i < NB_INPUTS; i++)
				transfer(1'b1, X_BASE + 8'(i), ~case_mem[base+i], got);
		end
		wait_done();
		for (int i = 0; i < NB_NEURONS; i++) begin
			transfer(1'b0, HOUT_BASE + 8'(i), '0, got);
			check_value($sformatf("h_out[%0d] case %0d", i, c),
				case_mem[base+NB_INPUTS+NB_NEURONS+i], got);
		end
		if (c == 1) begin
			for (int i = 0; i < NB_INPUTS; i++) begin
				transfer(1'b0, X_BASE + 8'(i), '0, got);
				check_value($sformatf("x[%0d] case %0d", i, c), case_mem[base+i], got);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int    adr;
		data_t got;
		errors = 0;
		timeouts = 0;
		checks = 0;
		lfsr = 32'h8c6a_fbb2;
		clk = 1'b0;
		rst_n = 1'b0;
		wb_req = '0;
		$readmemh("verification/gru_cases.hex", case_mem);
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		transfer(1'b0, STAT_ADR, '0, got);
		check_value("stat after reset", '0, got);
		for (int i = 0; i < NB_NEURONS; i++) begin
			transfer(1'b0, HOUT_BASE + 8'(i), '0, got);
			check_value($sformatf("h_out[%0d] after reset", i), '0, got);
		end

		for (int a = 0; a < MEM_DEPTH; a++)
			transfer(1'b1, 8'(a), case_mem[a], got);
		for (int n = 0; n < 16; n++) begin
			pick_addr(adr);
			transfer(1'b0, 8'(adr), '0, got);
			check_value($sformatf("weight[%0d]", adr), case_mem[adr], got);
		end

		for (int c = 0; c < NB_CASES; c++)
			run_case(c);

		$display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== verification/gru_cases.hex ====
// words 0x00-0x6b: weight memory, one row of twelve per line (gate z, r, h x neuron 0-3)
// then one line per case: x[0..3], h_prev[0..3], expected h[0..3]
// input weights, rows k = 0..3
0040 0000 0000 0000 0020 0020 0020 0020 0100 0000 0000 ff80
0000 0040 0000 0000 0020 0020 0020 0020 ff80 0100 0000 0000
0000 0000 0040 0000 0020 0020 0020 0020 0000 ff80 0100 0000
0000 0000 0000 0040 0020 0020 0020 0020 0000 0000 ff80 0100
// recurrent weights, rows k = 0..3
0080 0000 0000 0000 ffc0 0000 0000 0000 0080 0080 0080 0080
0000 0080 0000 0000 0000 ffc0 0000 0000 0080 0080 0080 0080
0000 0000 0080 0000 0000 0000 ffc0 0000 0080 0080 0080 0080
0000 0000 0000 0080 0000 0000 0000 ffc0 0080 0080 0080 0080
// biases
0000 0040 ffc0 0080 0000 0020 0040 ffe0 0000 0010 fff0 0020
// case 0, zero previous state, candidate clamps on two neurons
0100 0080 ff00 0040 0000 0000 0000 0000 0054 0068 ff60 fff4
// case 1, mixed previous state, x rewritten while busy
0020 ffe0 0000 0100 0080 ff80 0040 0000 0062 ffbe ffd7 0050
// case 2, large inputs, sigmoid and tanh clamp at both ends
0c00 f400 0400 f000 0100 ff00 0080 ff80 0100 ff00 00a0 ff00

// ==== verilog.f ====
src/gru_pkg.sv
src/gru_weight_mem.sv
src/gru_mac.sv
src/gru_activation.sv
src/gru_datapath.sv
src/gru_sequencer.sv
src/gru_wb_regs.sv
src/gru_cell_top.sv
verification/gru_cell_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the GRU cell testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module gru_cell_tb \
	-f verilog.f -Mdir obj_dir -o gru_cell_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/gru_cell_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "^No errors$" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
